// ==== udp_meas_macros.svh ====
// Build-time defaults for the UDP measurement streamer
// Include wherever a width, port, address or size default is needed
`ifndef UDP_MEAS_MACROS_SVH
`define UDP_MEAS_MACROS_SVH

// Stream word geometry
`define DATA_W 64
`define KEEP_W 8

// UDP ports
`define CMD_PORT      16'd1234
`define DATA_DST_PORT 16'd9999

// IPv4 addresses
`define LOCAL_IP       {8'd192, 8'd168, 8'd1, 8'd128}
`define DEFAULT_DST_IP {8'd192, 8'd168, 8'd1, 8'd100}

// Payload words per frame and buffer depth in words
`define FRAME_WORDS_DEF 1024
`define FIFO_DEPTH_DEF  4096

`endif

// ==== udp_hdr_pkg.sv ====
// Stream beat and UDP header types used by the datapath
// Import into modules that carry payload words or headers
`default_nettype none

`include "udp_meas_macros.svh"

package udp_hdr_pkg;

    // One stream word
    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [`KEEP_W-1:0] keep;
        logic               last;
        logic               user;
    } axis_beat_t;

    // Fields taken from an incoming UDP header
    typedef struct packed {
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } udp_rx_hdr_t;

    // Outgoing UDP header
    // TTL is not carried
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
    } udp_tx_hdr_t;

endpackage

`default_nettype wire

// ==== meas_cmd_pkg.sv ====
// Command word layout and opcodes for the measurement control path
// A command is the first 64-bit payload word of a frame on the command port
`default_nettype none

`include "udp_meas_macros.svh"

package meas_cmd_pkg;

    // Marker sits in the low half, opcode in the high half
    typedef struct packed {
        logic [31:0] opcode;
        logic [31:0] marker;
    } meas_cmd_fields_t;

    typedef union packed {
        logic [`DATA_W-1:0] raw;
        meas_cmd_fields_t   f;
    } meas_cmd_t;

    // "...." little-endian
    localparam logic [31:0] CMD_MARKER = 32'h2E2E2E2E;
    // "INIT" little-endian
    localparam logic [31:0] OP_INIT    = 32'h54494E49;
    // "FINI" little-endian
    localparam logic [31:0] OP_FINI    = 32'h494E4946;

endpackage

`default_nettype wire

// ==== udp_rx_filter.sv ====
// Receive side filter for UDP frames from the stack
// Takes one header per frame, forwards payload of frames on the command
// port and drains everything else; the sender IP of a match is kept
`timescale 1ns/1ps
`default_nettype none

`include "udp_meas_macros.svh"

module udp_rx_filter import udp_hdr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  udp_rx_hdr_t rx_hdr,
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  axis_beat_t  rx_pay,
    input  logic        rx_pay_valid,
    output logic        rx_pay_ready,
    output axis_beat_t  cmd_beat,
    output logic        cmd_valid,
    output logic [31:0] peer_ip
);

    logic in_frame;
    logic match_q;
    logic hdr_fire;
    logic pay_fire;

    assign hdr_fire = rx_hdr_valid && rx_hdr_ready;
    assign pay_fire = rx_pay_valid && rx_pay_ready;

    // Header only when no frame is open, payload only inside a frame
    assign rx_hdr_ready = !in_frame;
    assign rx_pay_ready = in_frame;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            match_q  <= 1'b0;
            peer_ip  <= `DEFAULT_DST_IP;
        end else begin
            if (hdr_fire) begin
                in_frame <= 1'b1;
                match_q  <= (rx_hdr.dst_port == `CMD_PORT);
                if (rx_hdr.dst_port == `CMD_PORT) begin
                    peer_ip <= rx_hdr.src_ip;
                end
            end else if (pay_fire && rx_pay.last) begin
                in_frame <= 1'b0;
                match_q  <= 1'b0;
            end
        end
    end

    // Non-matching beats are accepted and dropped here
    assign cmd_beat  = rx_pay;
    assign cmd_valid = pay_fire && match_q;

endmodule

`default_nettype wire

// ==== meas_cmd_decoder.sv ====
// Start/stop decoder for the filtered command stream
// Only the first word of each frame is looked at; run holds the result
`timescale 1ns/1ps
`default_nettype none

module meas_cmd_decoder
    import udp_hdr_pkg::*;
    import meas_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t cmd_beat,
    input  logic       cmd_valid,
    output logic       run
);

    logic      first_q;
    meas_cmd_t cmd;

    assign cmd.raw = cmd_beat.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_q <= 1'b1;
            run     <= 1'b0;
        end else if (cmd_valid) begin
            // Next word starts a new frame only after a last
            first_q <= cmd_beat.last;
            if (first_q && cmd.f.marker == CMD_MARKER) begin
                case (cmd.f.opcode)
                    OP_INIT: begin
                        run <= 1'b1;
                    end
                    OP_FINI: begin
                        run <= 1'b0;
                    end
                    default: begin
                        run <= run;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== count_frame_gen.sv ====
// Counter word source for measurement frames
// Emits FRAME_WORDS words per frame while run is high and always finishes
// the frame it has started; the counter runs on across frames
`timescale 1ns/1ps
`default_nettype none

`include "udp_meas_macros.svh"

module count_frame_gen import udp_hdr_pkg::*; #(
    parameter int FRAME_WORDS = `FRAME_WORDS_DEF
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       run,
    output axis_beat_t gen_beat,
    output logic       gen_valid,
    input  logic       gen_ready
);

    localparam int IDX_W = $clog2(FRAME_WORDS + 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_WORDS - 1);

    logic [`DATA_W-1:0] count;
    logic [IDX_W-1:0]   word_idx;
    logic               is_last;
    logic               accept;
    logic               hold;
    logic               mid_frame;

    assign is_last = (word_idx == LAST_IDX);
    assign accept  = gen_valid && gen_ready;

    // Stalled word stays up
    assign hold = gen_valid && !gen_ready;

    // More words owed to the current frame
    assign mid_frame = accept ? !is_last : (word_idx != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            gen_valid <= 1'b0;
            count     <= '0;
            word_idx  <= '0;
        end else begin
            gen_valid <= hold || mid_frame || run;
            if (accept) begin
                count    <= count + 1'b1;
                word_idx <= is_last ? '0 : word_idx + 1'b1;
            end
        end
    end

    assign gen_beat.data = count;
    assign gen_beat.keep = '1;
    assign gen_beat.last = is_last;
    assign gen_beat.user = 1'b0;

endmodule

`default_nettype wire

// ==== frame_fifo.sv ====
// Store-and-forward FIFO for stream frames
// A word is offered at the output only once the whole frame it belongs to
// has been written, so downstream never sees a partial frame
`timescale 1ns/1ps
`default_nettype none

`include "udp_meas_macros.svh"

module frame_fifo import udp_hdr_pkg::*; #(
    parameter int DEPTH = `FIFO_DEPTH_DEF
) (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    axis_beat_t     mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  word_cnt;
    logic [CW-1:0]  frame_cnt;
    logic           wr_en;
    logic           rd_en;
    logic           wr_end;
    logic           rd_end;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        next_ptr = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (word_cnt != CW'(DEPTH));
    assign out_valid = (frame_cnt != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;
    assign wr_end    = wr_en && in_beat.last;
    assign rd_end    = rd_en && out_beat.last;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    assign out_beat = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            word_cnt  <= '0;
            frame_cnt <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Occupancy in words and in complete frames
            word_cnt  <= word_cnt + CW'(wr_en) - CW'(rd_en);
            frame_cnt <= frame_cnt + CW'(wr_end) - CW'(rd_end);
        end
    end

endmodule

`default_nettype wire

// ==== udp_tx_framer.sv ====
// Transmit framer toward the UDP stack
// Offers one header per stored frame, then moves that frame's payload
// from the FIFO to the stack until last
`timescale 1ns/1ps
`default_nettype none

`include "udp_meas_macros.svh"

module udp_tx_framer import udp_hdr_pkg::*; #(
    parameter int FRAME_WORDS = `FRAME_WORDS_DEF
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] peer_ip,
    input  axis_beat_t  fifo_beat,
    input  logic        fifo_valid,
    output logic        fifo_ready,
    output udp_tx_hdr_t tx_hdr,
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output axis_beat_t  tx_pay,
    output logic        tx_pay_valid,
    input  logic        tx_pay_ready
);

    typedef enum logic {S_HDR, S_PAY} state_t;

    state_t      state;
    logic [31:0] dst_ip_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= S_HDR;
            tx_hdr_valid <= 1'b0;
        end else begin
            case (state)
                S_HDR: begin
                    if (tx_hdr_valid && tx_hdr_ready) begin
                        tx_hdr_valid <= 1'b0;
                        state        <= S_PAY;
                    end else if (fifo_valid) begin
                        tx_hdr_valid <= 1'b1;
                    end
                end
                default: begin
                    if (tx_pay_valid && tx_pay_ready && tx_pay.last) begin
                        state <= S_HDR;
                    end
                end
            endcase
        end
    end

    // Destination frozen while the header waits
    always_ff @(posedge clk) begin
        if (!tx_hdr_valid) begin
            dst_ip_q <= peer_ip;
        end
    end

    assign tx_hdr.src_ip   = `LOCAL_IP;
    assign tx_hdr.dst_ip   = dst_ip_q;
    assign tx_hdr.src_port = `CMD_PORT;
    assign tx_hdr.dst_port = `DATA_DST_PORT;
    assign tx_hdr.length   = 16'(FRAME_WORDS * 8 + 8);

    assign tx_pay       = fifo_beat;
    assign tx_pay_valid = (state == S_PAY) && fifo_valid;
    assign fifo_ready   = (state == S_PAY) && tx_pay_ready;

endmodule

`default_nettype wire

// ==== udp_meas_top.sv ====
// Measurement streamer top level
// Wires the command path (filter, decoder) to the data path
// (generator, frame FIFO, framer)
`timescale 1ns/1ps
`default_nettype none

`include "udp_meas_macros.svh"

module udp_meas_top import udp_hdr_pkg::*; #(
    parameter int FRAME_WORDS = `FRAME_WORDS_DEF,
    parameter int FIFO_DEPTH  = `FIFO_DEPTH_DEF
) (
    input  logic        clk,
    input  logic        rst,
    input  udp_rx_hdr_t rx_hdr,
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  axis_beat_t  rx_pay,
    input  logic        rx_pay_valid,
    output logic        rx_pay_ready,
    output udp_tx_hdr_t tx_hdr,
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output axis_beat_t  tx_pay,
    output logic        tx_pay_valid,
    input  logic        tx_pay_ready,
    output logic        running
);

    axis_beat_t  cmd_beat;
    logic        cmd_valid;
    logic [31:0] peer_ip;
    logic        run;
    axis_beat_t  gen_beat;
    logic        gen_valid;
    logic        gen_ready;
    axis_beat_t  fifo_beat;
    logic        fifo_valid;
    logic        fifo_ready;

    assign running = run;

    udp_rx_filter u_udp_rx_filter (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_pay       (rx_pay),
        .rx_pay_valid (rx_pay_valid),
        .rx_pay_ready (rx_pay_ready),
        .cmd_beat     (cmd_beat),
        .cmd_valid    (cmd_valid),
        .peer_ip      (peer_ip)
    );

    meas_cmd_decoder u_meas_cmd_decoder (
        .clk       (clk),
        .rst       (rst),
        .cmd_beat  (cmd_beat),
        .cmd_valid (cmd_valid),
        .run       (run)
    );

    count_frame_gen #(
        .FRAME_WORDS (FRAME_WORDS)
    ) u_count_frame_gen (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .gen_beat  (gen_beat),
        .gen_valid (gen_valid),
        .gen_ready (gen_ready)
    );

    frame_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_frame_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (gen_beat),
        .in_valid  (gen_valid),
        .in_ready  (gen_ready),
        .out_beat  (fifo_beat),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    udp_tx_framer #(
        .FRAME_WORDS (FRAME_WORDS)
    ) u_udp_tx_framer (
        .clk          (clk),
        .rst          (rst),
        .peer_ip      (peer_ip),
        .fifo_beat    (fifo_beat),
        .fifo_valid   (fifo_valid),
        .fifo_ready   (fifo_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_pay       (tx_pay),
        .tx_pay_valid (tx_pay_valid),
        .tx_pay_ready (tx_pay_ready)
    );

endmodule

`default_nettype wire

// ==== udp_meas_sva.sv ====
// Protocol assertions on the transmit side of the streamer
// Bound into udp_meas_top to watch the transmit handshakes
`timescale 1ns/1ps
`default_nettype none

module udp_meas_sva import udp_hdr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  udp_tx_hdr_t tx_hdr,
    input  logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    input  axis_beat_t  tx_pay,
    input  logic        tx_pay_valid,
    input  logic        tx_pay_ready
);

    // Set by an accepted header, cleared by the last payload word
    logic hdr_open;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_open <= 1'b0;
        end else if (tx_hdr_valid && tx_hdr_ready) begin
            hdr_open <= 1'b1;
        end else if (tx_pay_valid && tx_pay_ready && tx_pay.last) begin
            hdr_open <= 1'b0;
        end
    end

    hdr_held: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else $error("tx header dropped or changed while stalled");

    pay_held: assert property (@(posedge clk) disable iff (rst)
        tx_pay_valid && !tx_pay_ready |=> tx_pay_valid && $stable(tx_pay))
        else $error("tx payload dropped or changed while stalled");

    pay_after_hdr: assert property (@(posedge clk) disable iff (rst)
        tx_pay_valid |-> hdr_open)
        else $error("tx payload offered before its header");

endmodule

bind udp_meas_top udp_meas_sva u_udp_meas_sva (.*);

`default_nettype wire

// ==== tb_udp_meas.sv ====
// Testbench for the UDP measurement streamer
// Reads command frames and expectations from udp_meas_tests.txt, sends each
// command, then checks running, the transmit headers and the counter payload
`timescale 1ns/1ps
`default_nettype none

module tb_udp_meas
    import udp_hdr_pkg::*;
    import meas_cmd_pkg::*;
();

    localparam int FRAME_WORDS  = 16;
    localparam int RX_TIMEOUT   = 20;
    localparam int HDR_TIMEOUT  = 1000;
    localparam int QUIET_CYCLES = 200;
    localparam int BEAT_TIMEOUT = 100;
    localparam int MAX_DRAIN    = 320;
    localparam logic [31:0] RESET_IP  = 32'hC0A80164;
    localparam logic [31:0] OWN_IP    = 32'hC0A80180;
    // 16 payload words of 8 bytes plus the 8-byte UDP header
    localparam logic [15:0] FRAME_LEN = 16'd136;

    logic        clk;
    logic        rst;
    udp_rx_hdr_t rx_hdr;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    axis_beat_t  rx_pay;
    logic        rx_pay_valid;
    logic        rx_pay_ready;
    udp_tx_hdr_t tx_hdr;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    axis_beat_t  tx_pay;
    logic        tx_pay_valid;
    logic        tx_pay_ready;
    logic        running;

    // Reference model state
    logic [63:0] next_count;
    logic        model_run;
    logic [31:0] cur_ip;
    logic [31:0] next_hdr_ip;
    logic [31:0] rnd;
    int          errors;
    int          tests;
    int          failed_tests;
    bit          aborted;

    udp_meas_top #(
        .FRAME_WORDS (FRAME_WORDS)
    ) u_udp_meas_top (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_pay       (rx_pay),
        .rx_pay_valid (rx_pay_valid),
        .rx_pay_ready (rx_pay_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_pay       (tx_pay),
        .tx_pay_valid (tx_pay_valid),
        .tx_pay_ready (tx_pay_ready),
        .running      (running)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // All sampling and driving happens 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_test(input string name, input string what);
        $display("error in %0s: %0s", name, what);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
        if (exp !== act) begin
            $display("mismatch %0s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_hdr(input string name, input udp_tx_hdr_t exp, input udp_tx_hdr_t act);
        if (exp !== act) begin
            $display("mismatch %0s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("mismatch %0s: expected %0b actual %0b", name, exp, act);
            errors++;
        end
    endtask

    // One-beat command frame; stale tells whether a header was already waiting
    task automatic send_cmd(input string name, input logic [15:0] port, input logic [31:0] ip,
                            input logic [63:0] word, output bit stale);
        int waited;
        bit fired;
        stale  = 1'b0;
        rx_hdr = '{src_ip: ip, src_port: 16'd40000, dst_port: port};
        rx_hdr_valid = 1'b1;
        waited = 0;
        fired  = 1'b0;
        while (!fired && waited < RX_TIMEOUT) begin
            fired = rx_hdr_ready;
            next_cycle();
            waited++;
        end
        rx_hdr_valid = 1'b0;
        if (!fired) begin
            abort_test(name, "receive header was never accepted");
            return;
        end
        // A header already offered keeps the address it was offered with
        stale  = tx_hdr_valid;
        rx_pay = '{data: word, keep: 8'hFF, last: 1'b1, user: 1'b0};
        rx_pay_valid = 1'b1;
        waited = 0;
        fired  = 1'b0;
        while (!fired && waited < RX_TIMEOUT) begin
            fired = rx_pay_ready;
            next_cycle();
            waited++;
        end
        rx_pay_valid = 1'b0;
        if (!fired) begin
            abort_test(name, "receive payload was never accepted");
        end
    endtask

    // Takes one header and its payload; got stays low if no header shows up
    task automatic recv_frame(input string name, input int hdr_wait, output bit got);
        int          waited;
        int          i;
        bit          fired;
        udp_tx_hdr_t exp_hdr;
        axis_beat_t  exp_beat;
        got    = 1'b0;
        waited = 0;
        while (!tx_hdr_valid && waited < hdr_wait) begin
            next_cycle();
            waited++;
        end
        if (!tx_hdr_valid) begin
            return;
        end
        got = 1'b1;
        exp_hdr = '{src_ip: OWN_IP, dst_ip: next_hdr_ip, src_port: 16'd1234,
                    dst_port: 16'd9999, length: FRAME_LEN};
        check_hdr(name, exp_hdr, tx_hdr);
        next_hdr_ip  = cur_ip;
        tx_hdr_ready = 1'b1;
        next_cycle();
        tx_hdr_ready = 1'b0;
        for (i = 0; i < FRAME_WORDS && !aborted; i++) begin
            waited = 0;
            fired  = 1'b0;
            while (!fired && waited < BEAT_TIMEOUT) begin
                rnd = xorshift32(rnd);
                tx_pay_ready = (rnd[1:0] != 2'b00);
                if (tx_pay_valid && tx_pay_ready) begin
                    exp_beat = '{data: next_count, keep: 8'hFF,
                                 last: (i == FRAME_WORDS - 1), user: 1'b0};
                    check_beat(name, exp_beat, tx_pay);
                    next_count = next_count + 64'd1;
                    fired = 1'b1;
                end
                next_cycle();
                waited++;
            end
            if (!fired) begin
                abort_test(name, "payload word did not arrive");
            end
        end
        tx_pay_ready = 1'b0;
    endtask

    task automatic run_test(input string name, input logic [15:0] port, input logic [31:0] ip,
                            input logic [63:0] word, input int frames, input logic [31:0] exp_ip);
        int err0;
        int f;
        int drained;
        bit stale;
        bit got;
        err0 = errors;
        if (port == 16'd1234 && word[31:0] == CMD_MARKER) begin
            if (word[63:32] == OP_INIT) begin
                model_run = 1'b1;
            end else if (word[63:32] == OP_FINI) begin
                model_run = 1'b0;
            end
        end
        send_cmd(name, port, ip, word, stale);
        cur_ip = exp_ip;
        if (!stale) begin
            next_hdr_ip = exp_ip;
        end
        if (!aborted) begin
            check_bit(name, model_run, running);
        end
        for (f = 0; f < frames && !aborted; f++) begin
            recv_frame(name, HDR_TIMEOUT, got);
            if (!got) begin
                abort_test(name, "no frame header within the timeout");
            end
        end
        // After a stop the FIFO is emptied and the link must then stay quiet
        got     = 1'b1;
        drained = 0;
        while (!model_run && got && !aborted) begin
            recv_frame(name, QUIET_CYCLES, got);
            if (got) begin
                drained++;
            end
            if (drained > MAX_DRAIN) begin
                abort_test(name, "frames kept coming after the stop command");
            end
        end
        tests++;
        if (errors == err0) begin
            $display("test %-12s ok", name);
        end else begin
            failed_tests++;
            $display("test %-12s FAILED with %0d errors", name, errors - err0);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        string       name;
        logic [15:0] port;
        logic [31:0] src_ip;
        logic [31:0] exp_ip;
        logic [63:0] word;
        int          frames;
        rst          = 1'b1;
        rx_hdr       = '0;
        rx_hdr_valid = 1'b0;
        rx_pay       = '0;
        rx_pay_valid = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_pay_ready = 1'b0;
        next_count   = 64'd0;
        model_run    = 1'b0;
        cur_ip       = RESET_IP;
        next_hdr_ip  = RESET_IP;
        rnd          = 32'd89069;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        aborted      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();
        fd = $fopen("udp_meas_tests.txt", "r");
        if (fd == 0) begin
            abort_test("setup", "cannot open the test list");
        end
        while (fd != 0 && !$feof(fd) && !aborted) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() == 0 || line.getc(0) == 8'h23) begin
                continue;
            end
            code = $sscanf(line, "%s %d %h %h %d %h", name, port, src_ip, word, frames, exp_ip);
            if (code == 6) begin
                run_test(name, port, src_ip, word, frames, exp_ip);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0 && !aborted && tests > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== udp_meas_tests.txt ====
# name port(dec) src_ip(hex) cmd_word(hex) frames(dec) exp_ip(hex)
# cmd_word is the first payload word: opcode in bits 63:32, marker in bits 31:0
init_start 1234 c0a80132 54494e492e2e2e2e 3 c0a80132
other_port 4321 0a000001 494e49462e2e2e2e 2 c0a80132
no_marker  1234 c0a80133 494e494612345678 2 c0a80133
bad_opcode 1234 c0a80134 504f54532e2e2e2e 2 c0a80134
fini_stop  1234 c0a80134 494e49462e2e2e2e 0 c0a80134
idle_other 5000 0a000002 54494e492e2e2e2e 0 c0a80134
init_again 1234 c0a80165 54494e492e2e2e2e 4 c0a80165
fini_again 1234 c0a80165 494e49462e2e2e2e 0 c0a80165

// ==== tb.f ====
+incdir+.
udp_hdr_pkg.sv
meas_cmd_pkg.sv
udp_rx_filter.sv
meas_cmd_decoder.sv
count_frame_gen.sv
frame_fifo.sv
udp_tx_framer.sv
udp_meas_top.sv
udp_meas_sva.sv
tb_udp_meas.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_udp_meas -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_udp_meas > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
